// ==== ahb_mem_slave.f ====
rtl/ahb_mem_pkg.sv
rtl/ahb_xfer_ctrl.sv
rtl/ahb_burst_addr.sv
rtl/ahb_sram.sv
rtl/ahb_mem_slave.sv
test/ahb_mem_slave_props.sv
test/tb_ahb_mem_slave.sv

// ==== rtl/ahb_burst_addr.sv ====
`timescale 1ns/1ps

module ahb_burst_addr #(
  parameter int MEM_DEPTH = 32
) (
  input  logic                               hclk,
  input  logic                               hresetn,
  input  logic                               beat_start,
  input  logic                               beat_next,
  input  logic [ahb_mem_pkg::ADDR_W-1:0]     haddr,
  input  ahb_mem_pkg::hburst_t               hburst,
  output logic [$clog2(MEM_DEPTH)-1:0]       word_idx
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  ahb_mem_pkg::hburst_t burst_q;
  logic [IDX_W-1:0]     wrap_mask;
  logic [IDX_W-1:0]     idx_inc;
  logic [IDX_W-1:0]     idx_step;

  //////////////////////////////////////////////////
  // wrap boundary from the burst type
  //////////////////////////////////////////////////

  // beats of a wrapping burst, zero when it does not wrap
  function automatic int wrap_beats(ahb_mem_pkg::hburst_t burst);
    int beats;
    case (burst)
      ahb_mem_pkg::BURST_WRAP4:  beats = 4;
      ahb_mem_pkg::BURST_WRAP8:  beats = 8;
      ahb_mem_pkg::BURST_WRAP16: beats = 16;
      default:                   beats = 0;
    endcase
    return beats;
  endfunction

  always_comb
  begin
    if (wrap_beats(burst_q) == 0)
    begin
      // incrementing bursts roll over at the top of memory
      wrap_mask = '1;
    end
    else
    begin
      wrap_mask = IDX_W'(wrap_beats(burst_q) - 1);
    end
  end

  //////////////////////////////////////////////////
  // next beat index
  //////////////////////////////////////////////////

  assign idx_inc = word_idx + IDX_W'(1);

  // bits above the wrap boundary stay put
  assign idx_step = (word_idx & ~wrap_mask) | (idx_inc & wrap_mask);

  always_ff @(posedge hclk)
  begin
    if (!hresetn)
    begin
      word_idx <= '0;
      burst_q  <= ahb_mem_pkg::BURST_SINGLE;
    end
    else if (beat_start)
    begin
      // byte address to word index, upper bits alias
      word_idx <= haddr[IDX_W+1:2];
      burst_q  <= hburst;
    end
    else if (beat_next)
    begin
      word_idx <= idx_step;
    end
  end

endmodule

// ==== rtl/ahb_mem_pkg.sv ====
package ahb_mem_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  //////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR   = 3'b001,
    BURST_WRAP4  = 3'b010,
    BURST_INCR4  = 3'b011,
    BURST_WRAP8  = 3'b100,
    BURST_INCR8  = 3'b101,
    BURST_WRAP16 = 3'b110,
    BURST_INCR16 = 3'b111
  } hburst_t;

  //////////////////////////////////////////////////
  // slave data phase
  //////////////////////////////////////////////////

  // PH_READ_WAIT is the one wait cycle of every read
  typedef enum logic [1:0] {
    PH_IDLE      = 2'b00,
    PH_WRITE     = 2'b01,
    PH_READ_WAIT = 2'b10
  } xfer_phase_t;

endpackage

// ==== rtl/ahb_mem_slave.sv ====
`timescale 1ns/1ps

module ahb_mem_slave #(
  parameter int MEM_DEPTH = 32
) (
  input  logic                           hclk,
  input  logic                           hresetn,
  input  logic                           hsel,
  input  logic [ahb_mem_pkg::ADDR_W-1:0] haddr,
  input  logic                           hwrite,
  input  ahb_mem_pkg::htrans_t           htrans,
  input  ahb_mem_pkg::hburst_t           hburst,
  input  logic [ahb_mem_pkg::DATA_W-1:0] hwdata,
  input  logic                           hready,
  output logic                           hreadyout,
  output logic [ahb_mem_pkg::DATA_W-1:0] hrdata
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  logic             beat_start;
  logic             beat_next;
  logic             wr_en;
  logic             rd_en;
  logic [IDX_W-1:0] word_idx;

  //////////////////////////////////////////////////
  // transfer control
  //////////////////////////////////////////////////

  ahb_xfer_ctrl i_ahb_xfer_ctrl (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .hsel       (hsel),
    .hwrite     (hwrite),
    .hready     (hready),
    .htrans     (htrans),
    .hreadyout  (hreadyout),
    .beat_start (beat_start),
    .beat_next  (beat_next),
    .wr_en      (wr_en),
    .rd_en      (rd_en)
  );

  //////////////////////////////////////////////////
  // burst address and storage
  //////////////////////////////////////////////////

  ahb_burst_addr #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_ahb_burst_addr (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .beat_start (beat_start),
    .beat_next  (beat_next),
    .haddr      (haddr),
    .hburst     (hburst),
    .word_idx   (word_idx)
  );

  // index is stable for the whole data phase
  ahb_sram #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_ahb_sram (
    .hclk     (hclk),
    .hresetn  (hresetn),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .word_idx (word_idx),
    .hwdata   (hwdata),
    .hrdata   (hrdata)
  );

endmodule

// ==== rtl/ahb_sram.sv ====
`timescale 1ns/1ps

module ahb_sram #(
  parameter int MEM_DEPTH = 32
) (
  input  logic                           hclk,
  input  logic                           hresetn,
  input  logic                           wr_en,
  input  logic                           rd_en,
  input  logic [$clog2(MEM_DEPTH)-1:0]   word_idx,
  input  logic [ahb_mem_pkg::DATA_W-1:0] hwdata,
  output logic [ahb_mem_pkg::DATA_W-1:0] hrdata
);

  logic [ahb_mem_pkg::DATA_W-1:0] mem [MEM_DEPTH];

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  // hwdata is valid at the end of the write data phase
  always_ff @(posedge hclk)
  begin
    if (wr_en)
    begin
      mem[word_idx] <= hwdata;
    end
  end

  //////////////////////////////////////////////////
  // registered read
  //////////////////////////////////////////////////

  // holds between reads
  always_ff @(posedge hclk)
  begin
    if (!hresetn)
    begin
      hrdata <= '0;
    end
    else if (rd_en)
    begin
      hrdata <= mem[word_idx];
    end
  end

endmodule

// ==== rtl/ahb_xfer_ctrl.sv ====
`timescale 1ns/1ps

module ahb_xfer_ctrl (
  input  logic                 hclk,
  input  logic                 hresetn,
  input  logic                 hsel,
  input  logic                 hwrite,
  input  logic                 hready,
  input  ahb_mem_pkg::htrans_t htrans,
  output logic                 hreadyout,
  output logic                 beat_start,
  output logic                 beat_next,
  output logic                 wr_en,
  output logic                 rd_en
);

  logic                     accept;
  logic                     is_nonseq;
  logic                     is_seq;
  ahb_mem_pkg::xfer_phase_t phase;
  ahb_mem_pkg::xfer_phase_t phase_nxt;

  //////////////////////////////////////////////////
  // address phase acceptance
  //////////////////////////////////////////////////

  assign is_nonseq = (htrans == ahb_mem_pkg::HTRANS_NONSEQ);
  assign is_seq    = (htrans == ahb_mem_pkg::HTRANS_SEQ);

  // BUSY and IDLE never get through
  assign accept = hsel && hready && (is_nonseq || is_seq);

  assign beat_start = accept && is_nonseq;
  assign beat_next  = accept && is_seq;

  //////////////////////////////////////////////////
  // data phase FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    phase_nxt = ahb_mem_pkg::PH_IDLE;
    case (phase)
      ahb_mem_pkg::PH_READ_WAIT:
      begin
        // data goes out next cycle, bus sees hready low now
        phase_nxt = ahb_mem_pkg::PH_IDLE;
      end
      default:
      begin
        if (accept)
        begin
          if (hwrite)
          begin
            phase_nxt = ahb_mem_pkg::PH_WRITE;
          end
          else
          begin
            phase_nxt = ahb_mem_pkg::PH_READ_WAIT;
          end
        end
      end
    endcase
  end

  always_ff @(posedge hclk)
  begin
    if (!hresetn)
    begin
      phase     <= ahb_mem_pkg::PH_IDLE;
      hreadyout <= 1'b1;
    end
    else
    begin
      phase     <= phase_nxt;
      // low only for the wait cycle of a read
      hreadyout <= (phase_nxt != ahb_mem_pkg::PH_READ_WAIT);
    end
  end

  //////////////////////////////////////////////////
  // memory strobes
  //////////////////////////////////////////////////

  assign wr_en = (phase == ahb_mem_pkg::PH_WRITE);
  assign rd_en = (phase == ahb_mem_pkg::PH_READ_WAIT);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the AHB memory slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_ahb_mem_slave
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP" \
  -f ahb_mem_slave.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running past assertion errors so the testbench reports them
"./$BUILD_DIR/$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi

echo "no failure reported in $LOG"
exit 0

// ==== test/ahb_mem_slave_props.sv ====
`timescale 1ns/1ps

module ahb_mem_slave_props (
  input logic                 hclk,
  input logic                 hresetn,
  input logic                 hsel,
  input logic                 hwrite,
  input logic                 hready,
  input ahb_mem_pkg::htrans_t htrans,
  input logic                 hreadyout,
  input logic                 wr_en,
  input logic                 rd_en
);

  int unsigned fail_count = 0;
  logic        read_accept;

  assign read_accept = hsel && hready && !hwrite &&
                       (htrans == ahb_mem_pkg::HTRANS_NONSEQ ||
                        htrans == ahb_mem_pkg::HTRANS_SEQ);

  //////////////////////////////////////////////////
  // ready timing
  //////////////////////////////////////////////////

  // one wait state per read
  no_double_wait: assert property (@(posedge hclk) disable iff (!hresetn)
    !hreadyout |=> hreadyout)
  else
  begin
    $error("hreadyout low two cycles in a row");
    fail_count = fail_count + 1;
  end

  fall_after_read: assert property (@(posedge hclk) disable iff (!hresetn)
    $fell(hreadyout) |-> $past(read_accept))
  else
  begin
    $error("hreadyout fell without an accepted read");
    fail_count = fail_count + 1;
  end

  no_rd_wr_overlap: assert property (@(posedge hclk) disable iff (!hresetn)
    !(wr_en && rd_en))
  else
  begin
    $error("wr_en and rd_en high together");
    fail_count = fail_count + 1;
  end

endmodule

bind ahb_xfer_ctrl ahb_mem_slave_props i_ahb_mem_slave_props (
  .hclk      (hclk),
  .hresetn   (hresetn),
  .hsel      (hsel),
  .hwrite    (hwrite),
  .hready    (hready),
  .htrans    (htrans),
  .hreadyout (hreadyout),
  .wr_en     (wr_en),
  .rd_en     (rd_en)
);

// ==== test/tb_ahb_mem_slave.sv ====
`timescale 1ns/1ps

module tb_ahb_mem_slave;

  localparam int MEM_DEPTH     = 32;
  localparam int IDX_W         = $clog2(MEM_DEPTH);
  localparam int DATA_W        = ahb_mem_pkg::DATA_W;
  localparam int ADDR_W        = ahb_mem_pkg::ADDR_W;
  localparam int RESET_CYCLES  = 8;
  localparam int READY_TIMEOUT = 20;
  localparam int SEED          = 94220;

  typedef enum {DP_NONE, DP_WRITE, DP_READ} data_phase_t;

  logic                 hclk;
  logic                 hresetn;
  logic                 hsel;
  logic [ADDR_W-1:0]    haddr;
  logic                 hwrite;
  ahb_mem_pkg::htrans_t htrans;
  ahb_mem_pkg::hburst_t hburst;
  logic [DATA_W-1:0]    hwdata;
  logic                 hready;
  logic                 hreadyout;
  logic [DATA_W-1:0]    hrdata;

  logic [DATA_W-1:0] model_mem [MEM_DEPTH];
  logic [IDX_W-1:0]  touched [$];
  data_phase_t       dp_kind;
  logic [DATA_W-1:0] dp_wdata;
  logic [DATA_W-1:0] dp_rexp;
  int                rdata_errs;
  int                ready_errs;
  int unsigned       seed_ret;

  // single slave, so hready is the slave's own
  assign hready = hreadyout;

  ahb_mem_slave i_ahb_mem_slave (
    .hclk      (hclk),
    .hresetn   (hresetn),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .htrans    (htrans),
    .hburst    (hburst),
    .hwdata    (hwdata),
    .hready    (hready),
    .hreadyout (hreadyout),
    .hrdata    (hrdata)
  );

  always #20 hclk = ~hclk;

  //////////////////////////////////////////////////
  // compare and report
  //////////////////////////////////////////////////

  task automatic check_rdata(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s hrdata %08h, expected %08h", $time, what, got, exp);
      rdata_errs++;
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s hreadyout %b, expected %b", $time, what, got, exp);
      ready_errs++;
    end
  endtask

  function automatic int unsigned assert_fails();
    return i_ahb_mem_slave.i_ahb_xfer_ctrl.i_ahb_mem_slave_props.fail_count;
  endfunction

  task automatic print_error_counts();
    $display("errors: rdata %0d, ready %0d, assertions %0d", rdata_errs, ready_errs,
             assert_fails());
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s for %0d cycles at %0t", what, READY_TIMEOUT, $time);
    print_error_counts();
    $display("Simulation FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int fixed_len(input ahb_mem_pkg::hburst_t burst);
    case (burst)
      ahb_mem_pkg::BURST_WRAP4, ahb_mem_pkg::BURST_INCR4:   return 4;
      ahb_mem_pkg::BURST_WRAP8, ahb_mem_pkg::BURST_INCR8:   return 8;
      ahb_mem_pkg::BURST_WRAP16, ahb_mem_pkg::BURST_INCR16: return 16;
      default:                                              return 1;
    endcase
  endfunction

  // wrap bursts stay inside their aligned block
  function automatic logic [IDX_W-1:0] model_next(input logic [IDX_W-1:0] idx,
                                                  input ahb_mem_pkg::hburst_t burst);
    int len;
    int base;
    len = fixed_len(burst);
    if (!(burst inside {ahb_mem_pkg::BURST_WRAP4, ahb_mem_pkg::BURST_WRAP8,
                        ahb_mem_pkg::BURST_WRAP16}))
    begin
      return IDX_W'((int'(idx) + 1) % MEM_DEPTH);
    end
    base = int'(idx) - (int'(idx) % len);
    return IDX_W'(base + ((int'(idx) % len) + 1) % len);
  endfunction

  function automatic logic [IDX_W-1:0] random_idx();
    return IDX_W'($urandom_range(0, MEM_DEPTH - 1));
  endfunction

  // upper bits random, they alias
  function automatic logic [ADDR_W-1:0] make_haddr(input logic [IDX_W-1:0] idx);
    logic [ADDR_W-1:0] a;
    a = $urandom;
    a[IDX_W+1:0] = {idx, 2'b00};
    return a;
  endfunction

  //////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!hreadyout && waited < READY_TIMEOUT)
    begin
      @(negedge hclk);
      waited++;
    end
    if (!hreadyout)
    begin
      stop_on_timeout("hreadyout stayed low");
    end
  endtask

  // one address phase, overlapping the data phase before it
  task automatic bus_step(input ahb_mem_pkg::htrans_t tr, input logic sel,
                          input logic [ADDR_W-1:0] addr, input logic wr,
                          input ahb_mem_pkg::hburst_t burst, input logic [DATA_W-1:0] wdata,
                          input logic [IDX_W-1:0] idx);
    logic taken;
    hsel   = sel;
    htrans = tr;
    haddr  = addr;
    hwrite = wr;
    hburst = burst;
    hwdata = (dp_kind == DP_WRITE) ? dp_wdata : $urandom;
    if (dp_kind == DP_READ)
    begin
      check_ready(hreadyout, 1'b0, "read wait");
      if (!hreadyout)
      begin
        @(negedge hclk);
        check_ready(hreadyout, 1'b1, "read data");
      end
    end
    else
    begin
      check_ready(hreadyout, 1'b1, "write or idle");
    end
    wait_ready();
    if (dp_kind == DP_READ)
    begin
      check_rdata(hrdata, dp_rexp, "read beat");
    end
    @(posedge hclk);
    taken = sel && (tr == ahb_mem_pkg::HTRANS_NONSEQ || tr == ahb_mem_pkg::HTRANS_SEQ);
    if (!taken)
    begin
      dp_kind = DP_NONE;
    end
    else if (wr)
    begin
      dp_kind        = DP_WRITE;
      dp_wdata       = wdata;
      model_mem[idx] = wdata;
    end
    else
    begin
      dp_kind = DP_READ;
      dp_rexp = model_mem[idx];
    end
    @(negedge hclk);
  endtask

  task automatic write_single(input logic [IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
    bus_step(ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, make_haddr(idx), 1'b1,
             ahb_mem_pkg::BURST_SINGLE, data, idx);
  endtask

  task automatic read_single(input logic [IDX_W-1:0] idx);
    bus_step(ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, make_haddr(idx), 1'b0,
             ahb_mem_pkg::BURST_SINGLE, '0, idx);
  endtask

  // deselected or IDLE cycles that look like writes
  task automatic idle_cycles(input int n);
    int c;
    for (c = 0; c < n; c++)
    begin
      if ($urandom_range(0, 1) == 1)
      begin
        bus_step(ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, $urandom, 1'b1,
                 ahb_mem_pkg::BURST_SINGLE, $urandom, '0);
      end
      else
      begin
        bus_step(ahb_mem_pkg::HTRANS_IDLE, 1'b1, $urandom, 1'b1,
                 ahb_mem_pkg::BURST_SINGLE, $urandom, '0);
      end
    end
  endtask

  // SEQ beats carry a random haddr, the slave counts on its own
  task automatic run_burst(input logic wr, input ahb_mem_pkg::hburst_t burst,
                           input logic [IDX_W-1:0] start, input int beats, input logic busy_ok);
    logic [IDX_W-1:0] cur;
    int               b;
    cur = start;
    for (b = 0; b < beats; b++)
    begin
      if (b == 0)
      begin
        bus_step(ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, make_haddr(cur), wr, burst, $urandom, cur);
      end
      else
      begin
        if (busy_ok && $urandom_range(0, 2) == 0)
        begin
          bus_step(ahb_mem_pkg::HTRANS_BUSY, 1'b1, $urandom, wr, burst, $urandom, cur);
        end
        cur = model_next(cur, burst);
        bus_step(ahb_mem_pkg::HTRANS_SEQ, 1'b1, $urandom, wr, burst, $urandom, cur);
      end
      touched.push_back(cur);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int                   i;
    int                   k;
    int                   beats;
    int                   base;
    logic [IDX_W-1:0]     idx;
    logic [IDX_W-1:0]     start;
    ahb_mem_pkg::hburst_t burst;
    ahb_mem_pkg::hburst_t incr_kinds [3];
    ahb_mem_pkg::hburst_t wrap_kinds [3];

    hclk       = 1'b0;
    hresetn    = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    hwrite     = 1'b0;
    htrans     = ahb_mem_pkg::HTRANS_IDLE;
    hburst     = ahb_mem_pkg::BURST_SINGLE;
    hwdata     = '0;
    dp_kind    = DP_NONE;
    dp_wdata   = '0;
    dp_rexp    = '0;
    rdata_errs = 0;
    ready_errs = 0;
    incr_kinds = '{ahb_mem_pkg::BURST_INCR4, ahb_mem_pkg::BURST_INCR8, ahb_mem_pkg::BURST_INCR16};
    wrap_kinds = '{ahb_mem_pkg::BURST_WRAP4, ahb_mem_pkg::BURST_WRAP8, ahb_mem_pkg::BURST_WRAP16};
    seed_ret   = $urandom(SEED);

    repeat (RESET_CYCLES)
    begin
      @(negedge hclk);
      check_ready(hreadyout, 1'b1, "during reset");
    end
    hresetn = 1'b1;
    @(negedge hclk);
    check_ready(hreadyout, 1'b1, "first cycle out of reset");

    // every word written once before any read
    for (i = 0; i < MEM_DEPTH; i++)
    begin
      write_single(IDX_W'(i), $urandom);
    end
    read_single(random_idx());
    idle_cycles(2);

    // single transfers, some read straight back
    for (k = 0; k < 60; k++)
    begin
      idx = random_idx();
      if ($urandom_range(0, 1) == 1)
      begin
        write_single(idx, $urandom);
        if ($urandom_range(0, 2) == 0)
        begin
          read_single(idx);
        end
      end
      else
      begin
        read_single(idx);
      end
    end
    idle_cycles(2);

    // fixed incrementing writes, last ones roll over the top
    for (k = 0; k < 9; k++)
    begin
      burst = incr_kinds[k % 3];
      start = (k >= 6) ? IDX_W'(MEM_DEPTH - int'($urandom_range(1, 3))) : random_idx();
      touched.delete();
      run_burst(1'b1, burst, start, fixed_len(burst), 1'b0);
      idle_cycles(1);
      for (i = 0; i < touched.size(); i++)
      begin
        read_single(touched[i]);
      end
      idle_cycles(1);
    end

    // wrapping write then read, both from unaligned starts
    for (k = 0; k < 9; k++)
    begin
      burst = wrap_kinds[k % 3];
      beats = fixed_len(burst);
      base  = int'($urandom_range(0, MEM_DEPTH / beats - 1)) * beats;
      start = IDX_W'(base + int'($urandom_range(1, beats - 1)));
      run_burst(1'b1, burst, start, beats, 1'b0);
      start = IDX_W'(base + int'($urandom_range(1, beats - 1)));
      run_burst(1'b0, burst, start, beats, 1'b0);
      idle_cycles(1);
    end

    // undefined length with BUSY, then idle traffic
    for (k = 0; k < 12; k++)
    begin
      run_burst($urandom_range(0, 1) == 1, ahb_mem_pkg::BURST_INCR, random_idx(),
                int'($urandom_range(1, 12)), 1'b1);
      idle_cycles(int'($urandom_range(1, 4)));
    end

    // whole memory back in one INCR read
    run_burst(1'b0, ahb_mem_pkg::BURST_INCR, random_idx(), MEM_DEPTH, 1'b0);
    idle_cycles(2);

    print_error_counts();
    if (rdata_errs == 0 && ready_errs == 0 && assert_fails() == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
